// ==== common/huff_pkg.sv ====
`default_nettype none

package huff_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int CHUNK_BITS  = 10;  // Chunk width, same as longest code
  localparam int SYM_BITS    = 5;   // Symbol index and output value
  localparam int LEN_BITS    = 4;   // Code length, 3 to 10
  localparam int NUM_SYMBOLS = 32;

  // ========================================
  // Code table, left-aligned in a chunk
  // ========================================
  localparam logic [CHUNK_BITS-1:0] CODE_TABLE [NUM_SYMBOLS] = '{
    10'b0100000000,  // S
    10'b0010000000,  // K
    10'b0000000000,  // R
    10'b1111000000,  // J
    10'b1110000000,  // T
    10'b1011000000,  // Q
    10'b1010000000,  // I
    10'b1001000000,  // U
    10'b1000000000,  // L
    10'b1101000000,  // V
    10'b1100100000,  // H
    10'b1100000000,  // P
    10'b0110100000,  // M
    10'b0110000000,  // W
    10'b0111110000,  // G
    10'b0111010000,  // X
    10'b1101111000,  // O
    10'b1101110000,  // F
    10'b1101100000,  // N
    10'b0111100000,  // Y
    10'b0111000000,  // E
    10'b1101101100,  // Z
    10'b0111101100,  // a
    10'b0111101000,  // D
    10'b0111001000,  // C
    10'b1101101010,  // B
    10'b1101101001,  // d
    10'b0111001100,  // e
    10'b0111001101,  // c
    10'b1101101000,  // b
    10'b0111001111,  // f
    10'b0111001110   // A
  };

  // Code length per symbol index
  localparam logic [LEN_BITS-1:0] LEN_TABLE [NUM_SYMBOLS] = '{
    3, 3, 3, 4, 4, 4, 4, 4,      // S K R J T Q I U
    4, 5, 5, 5, 5, 5, 6, 6,      // L V H P M W G X
    7, 7, 7, 7, 7, 8, 8, 8,      // O F N Y E Z a D
    8, 9, 10, 10, 10, 10, 10, 10 // C B d e c b f A
  };

  // ========================================
  // Output value per symbol index
  // ========================================
  localparam logic [SYM_BITS-1:0] VALUE_TABLE [NUM_SYMBOLS] = '{
    18, 10, 17, 9, 19, 16, 8, 20,  // S K R J T Q I U
    11, 21, 7, 15, 12, 22, 6, 23,  // L V H P M W G X
    14, 5, 13, 24, 4, 25, 26, 3,   // O F N Y E Z a D
    2, 1, 29, 30, 28, 27, 31, 0    // C B d e c b f A
  };

  // Every 10-bit head matches exactly one entry. The lengths give
  // a Kraft sum of one, so no head falls outside the table

endpackage

`default_nettype wire

// ==== window/bit_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_window #(
  parameter int WINDOW_BITS = 20  // At least two chunks
) (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic                           chunk_valid,
  input  wire logic [huff_pkg::CHUNK_BITS-1:0] chunk_data,
  input  wire logic [huff_pkg::LEN_BITS-1:0]   sym_len,
  output logic                                chunk_ready,
  output logic [huff_pkg::CHUNK_BITS-1:0]     head,
  output logic                                head_valid
);

  import huff_pkg::*;

  localparam int FILL_W = $clog2(WINDOW_BITS + 1);

  localparam logic [FILL_W-1:0] READY_MAX = FILL_W'(WINDOW_BITS - CHUNK_BITS);
  localparam logic [FILL_W-1:0] CHUNK_W   = FILL_W'(CHUNK_BITS);

  // ========================================
  // Window state
  // ========================================
  // Bits are held left-aligned, bits below the fill stay zero
  logic [WINDOW_BITS-1:0] win_q;
  logic [FILL_W-1:0]      fill_q;     // Valid bits in window

  logic [WINDOW_BITS-1:0] win_shifted;
  logic [WINDOW_BITS-1:0] chunk_ext;  // Chunk placed at the top
  logic [WINDOW_BITS-1:0] win_next;
  logic [FILL_W-1:0]      shift_amt;
  logic [FILL_W-1:0]      fill_left;  // Fill after the shift
  logic [FILL_W-1:0]      fill_next;
  logic                   chunk_accept;

  // ========================================
  // Status from fill
  // ========================================
  assign chunk_ready  = (fill_q <= READY_MAX);  // Room for one more chunk
  assign head_valid   = (fill_q >= CHUNK_W);    // Full head present
  assign head         = win_q[WINDOW_BITS-1 -: CHUNK_BITS];
  assign chunk_accept = chunk_valid && chunk_ready;

  // Drop the matched code only when it was really decoded
  assign shift_amt   = head_valid ? FILL_W'(sym_len) : '0;
  assign win_shifted = win_q << shift_amt;
  assign fill_left   = fill_q - shift_amt;

  assign chunk_ext = {chunk_data, {(WINDOW_BITS - CHUNK_BITS){1'b0}}};

  // Shift and append happen in the same edge; the new chunk lands
  // right below the bits that remain after the shift
  always_comb begin
    win_next  = win_shifted;
    fill_next = fill_left;
    if (chunk_accept) begin
      win_next  = win_shifted | (chunk_ext >> fill_left);  // Append below
      fill_next = fill_left + CHUNK_W;
    end
  end

  // ========================================
  // Registers
  // ========================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      win_q  <= '0;  // Keeps the zero-below-fill rule from the start
      fill_q <= '0;
    end else begin
      win_q  <= win_next;
      fill_q <= fill_next;
    end
  end

endmodule

`default_nettype wire

// ==== decode/code_matcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module code_matcher (
  input  wire logic [huff_pkg::CHUNK_BITS-1:0] head,
  output logic [huff_pkg::SYM_BITS-1:0]        sym_index,
  output logic [huff_pkg::LEN_BITS-1:0]        sym_len
);

  import huff_pkg::*;

  // ========================================
  // Per-symbol compare
  // ========================================
  logic [NUM_SYMBOLS-1:0] match;  // One-hot for a complete code

  for (genvar i = 0; i < NUM_SYMBOLS; i++) begin : g_cmp
    // Keeps only the leading code bits of this entry
    localparam logic [CHUNK_BITS-1:0] MASK =
      ~({CHUNK_BITS{1'b1}} >> LEN_TABLE[i]);

    assign match[i] = ((head & MASK) == CODE_TABLE[i]);
  end

  // ========================================
  // One-hot encode
  // ========================================
  // The code is prefix-free, so ORing the selected entries gives
  // the single match without a priority chain
  always_comb begin
    sym_index = '0;
    sym_len   = '0;
    for (int k = 0; k < NUM_SYMBOLS; k++) begin
      if (match[k]) begin
        sym_index = sym_index | SYM_BITS'(k);
        sym_len   = sym_len | LEN_TABLE[k];
      end
    end
  end

endmodule

`default_nettype wire

// ==== decode/symbol_lut.sv ====
`timescale 1ns/1ps
`default_nettype none

module symbol_lut (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          head_valid,
  input  wire logic [huff_pkg::SYM_BITS-1:0] sym_index,
  input  wire logic [huff_pkg::LEN_BITS-1:0] sym_len,
  output logic                               out_valid,
  output logic [huff_pkg::SYM_BITS-1:0]      out_value,
  output logic [huff_pkg::LEN_BITS-1:0]      out_len
);

  import huff_pkg::*;

  // ========================================
  // Value lookup
  // ========================================
  logic [SYM_BITS-1:0] lut_value;  // Decoded output value

  assign lut_value = VALUE_TABLE[sym_index];

  // ========================================
  // Output stage
  // ========================================
  // One pulse per decoded symbol, no back-pressure
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= head_valid;
    end
  end

  // Value and length hold between symbols
  always_ff @(posedge clk) begin
    if (head_valid) begin
      out_value <= lut_value;
      out_len   <= sym_len;    // Same length the window shifted by
    end
  end

endmodule

`default_nettype wire

// ==== logic/huffman_decoder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module huffman_decoder_top #(
  parameter int WINDOW_BITS = 20  // Two chunks
) (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic                           chunk_valid,
  input  wire logic [huff_pkg::CHUNK_BITS-1:0] chunk_data,
  output logic                                chunk_ready,
  output logic                                out_valid,
  output logic [huff_pkg::SYM_BITS-1:0]       out_value,
  output logic [huff_pkg::LEN_BITS-1:0]       out_len
);

  import huff_pkg::*;

  // ========================================
  // Internal nets
  // ========================================
  logic [CHUNK_BITS-1:0] head;       // Top bits of the window
  logic                  head_valid; // Window holds a full head
  logic [SYM_BITS-1:0]   sym_index;
  logic [LEN_BITS-1:0]   sym_len;

  // Bit window, shifts out decoded codes and appends chunks
  bit_window #(
    .WINDOW_BITS (WINDOW_BITS)
  ) u_bit_window (
    .clk         (clk),
    .rst         (rst),
    .chunk_valid (chunk_valid),
    .chunk_data  (chunk_data),
    .sym_len     (sym_len),
    .chunk_ready (chunk_ready),
    .head        (head),
    .head_valid  (head_valid)
  );

  // Single-cycle prefix match
  code_matcher u_code_matcher (
    .head      (head),
    .sym_index (sym_index),
    .sym_len   (sym_len)
  );

  // Value lookup and output register
  symbol_lut u_symbol_lut (
    .clk        (clk),
    .rst        (rst),
    .head_valid (head_valid),
    .sym_index  (sym_index),
    .sym_len    (sym_len),
    .out_valid  (out_valid),
    .out_value  (out_value),
    .out_len    (out_len)
  );

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter real PERIOD_NS = 4.0  // 250 MHz
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // First rising edge comes half a period after time zero
  always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// ==== sim/huffman_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module huffman_sva (
  input wire logic                          clk,
  input wire logic                          rst,
  input wire logic                          chunk_ready,
  input wire logic                          out_valid,
  input wire logic [huff_pkg::LEN_BITS-1:0] out_len
);

  // Every emitted length is one of the table lengths
  a_len_range: assert property (@(posedge clk) disable iff (!rst)
    out_valid |-> (out_len >= 3 && out_len <= 10))
    else $error("out_len %0d outside 3 to 10", out_len);

  // Output register cleared while reset is held
  a_quiet_in_reset: assert property (@(posedge clk) !rst |=> !out_valid)
    else $error("out_valid high during reset");

  a_ready_after_reset: assert property (@(posedge clk) $rose(rst) |-> chunk_ready)
    else $error("chunk_ready low in the first cycle after reset");  // Window is empty

endmodule

bind huffman_decoder_top huffman_sva u_sva (
  .clk         (clk),
  .rst         (rst),
  .chunk_ready (chunk_ready),
  .out_valid   (out_valid),
  .out_len     (out_len)
);

`default_nettype wire

// ==== sim/tb_huffman.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_huffman;

  import huff_pkg::*;

  localparam int WINDOW_BITS = 20;   // Two chunks
  localparam int TAIL_IDLE   = 30;   // Idle cycles after the last chunk
  localparam int MODE_RANDOM = 0;
  localparam int MODE_TABLE  = 1;    // Every symbol once, shuffled
  localparam int MODE_REUSE  = 2;    // Same symbols as the last test

  logic                  clk;
  logic                  rst;
  logic                  chunk_valid;
  logic [CHUNK_BITS-1:0] chunk_data;
  logic                  chunk_ready;
  logic                  out_valid;
  logic [SYM_BITS-1:0]   out_value;
  logic [LEN_BITS-1:0]   out_len;

  // ========================================
  // Model state
  // ========================================
  bit                   stream_q[$];  // Encoded bits, first sent first
  int unsigned          picks_q[$];   // Symbol indices in stream order
  int unsigned          exp_q[$];     // Symbols still to come out
  bit [NUM_SYMBOLS-1:0] seen;
  int                   fill_model;   // Bits the window should hold
  int                   errors;
  int                   out_count;
  int                   accepted;
  int                   stalls;
  int                   planned_chunks;
  int                   test_count;

  clk_gen #(.PERIOD_NS(4.0)) u_clk_gen (.clk(clk));

  huffman_decoder_top #(
    .WINDOW_BITS (WINDOW_BITS)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .chunk_valid (chunk_valid),
    .chunk_data  (chunk_data),
    .chunk_ready (chunk_ready),
    .out_valid   (out_valid),
    .out_value   (out_value),
    .out_len     (out_len)
  );

  // ========================================
  // Monitor
  // ========================================
  // A symbol seen here was shifted out of the window one edge earlier
  always @(posedge clk) begin : monitor
    int unsigned idx;
    if (!rst) begin
      fill_model = 0;
    end else begin
      if (out_valid) begin
        out_count++;
        if (exp_q.size() == 0) begin
          $display("Unexpected output at %0d ns: value %0d came with no symbol left", $time,
                   out_value);
          errors++;
        end else begin
          idx = exp_q.pop_front();
          fill_model -= LEN_TABLE[idx];  // Code bits dropped from the top
          if (out_value !== VALUE_TABLE[idx] || out_len !== LEN_TABLE[idx]) begin
            $display("Mismatch at %0d ns: output %0d index %0d got value %0d len %0d, %s %0d %0d",
                     $time, out_count, idx, out_value, out_len, "expected",
                     VALUE_TABLE[idx], LEN_TABLE[idx]);
            errors++;
          end else begin
            seen[idx] = 1'b1;
          end
        end
      end
      // Room for one more chunk
      if (chunk_ready !== (fill_model <= WINDOW_BITS - CHUNK_BITS)) begin
        $display("Mismatch at %0d ns: chunk_ready is %b with %0d bits in the window",
                 $time, chunk_ready, fill_model);
        errors++;
      end
      if (chunk_valid) begin
        if (chunk_ready) begin
          accepted++;
          fill_model += CHUNK_BITS;
        end else begin
          stalls++;  // Chunk waits for room
        end
      end
    end
  end

  // ========================================
  // Stimulus helpers
  // ========================================
  task automatic apply_reset();
    @(posedge clk);
    rst         <= 1'b0;
    chunk_valid <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b1;
  endtask

  task automatic build_stream(input int mode, input int n_sym, output int n_chunks);
    int unsigned starts_q[$];
    int unsigned tmp;
    int          j;
    stream_q.delete();
    exp_q.delete();
    if (mode != MODE_REUSE) begin
      picks_q.delete();
    end
    if (mode == MODE_TABLE) begin
      for (int k = 0; k < NUM_SYMBOLS; k++) begin
        picks_q.push_back(k);
      end
      for (int k = NUM_SYMBOLS - 1; k > 0; k--) begin
        j          = $urandom_range(k);
        tmp        = picks_q[k];
        picks_q[k] = picks_q[j];
        picks_q[j] = tmp;
      end
      picks_q.push_back(NUM_SYMBOLS - 1);  // Ten-bit filler so the last entry decodes
    end else if (mode == MODE_RANDOM) begin
      for (int k = 0; k < n_sym; k++) begin
        picks_q.push_back($urandom_range(NUM_SYMBOLS - 1));
      end
    end
    foreach (picks_q[i]) begin
      starts_q.push_back(stream_q.size());
      for (int b = 0; b < LEN_TABLE[picks_q[i]]; b++) begin
        stream_q.push_back(CODE_TABLE[picks_q[i]][CHUNK_BITS-1-b]);
      end
    end
    while (stream_q.size() % CHUNK_BITS != 0) begin
      stream_q.push_back($urandom_range(1));  // Random pad bits
    end
    n_chunks = stream_q.size() / CHUNK_BITS;
    planned_chunks += n_chunks;
    // A code is decoded only if a full head starts at it
    foreach (picks_q[i]) begin
      if (starts_q[i] + CHUNK_BITS <= stream_q.size()) begin
        exp_q.push_back(picks_q[i]);
      end
    end
  endtask

  function automatic logic [CHUNK_BITS-1:0] chunk_at(input int c);
    logic [CHUNK_BITS-1:0] w;
    for (int b = 0; b < CHUNK_BITS; b++) begin
      w[CHUNK_BITS-1-b] = stream_q[c * CHUNK_BITS + b];  // First bit in the MSB
    end
    return w;
  endfunction

  task automatic send_chunks(input int n_chunks, input int gap_pct);
    int sent;
    bit presenting;
    sent       = 0;
    presenting = 1'b0;
    @(posedge clk);
    while (sent < n_chunks) begin
      if (!presenting) begin
        if ($urandom_range(99) < gap_pct) begin
          chunk_valid <= 1'b0;
        end else begin
          chunk_valid <= 1'b1;
          chunk_data  <= chunk_at(sent);
          presenting  = 1'b1;
        end
      end
      @(posedge clk);
      if (presenting && chunk_ready) begin  // Taken at this edge
        sent++;
        presenting = 1'b0;
      end
    end
    chunk_valid <= 1'b0;
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic run_reset_test();
    int err0;
    err0 = errors;
    apply_reset();
    @(posedge clk);
    if (out_valid !== 1'b0) begin
      $display("Mismatch at %0d ns: out_valid is %b after reset", $time, out_valid);
      errors++;
    end
    if (chunk_ready !== 1'b1) begin
      $display("Mismatch at %0d ns: chunk_ready is %b after reset", $time, chunk_ready);
      errors++;
    end
    repeat (5) @(posedge clk);
    test_count++;
    $display("Test %-12s : %s", "reset", (errors == err0) ? "ok" : "failed");
  endtask

  task automatic run_stream_test(input string name, input int mode, input int n_sym,
                                 input int gap_pct, input bit expect_stall);
    int err0;
    int out0;
    int stall0;
    int n_chunks;
    int n_exp;
    int waited;
    err0 = errors;
    apply_reset();
    build_stream(mode, n_sym, n_chunks);
    n_exp  = exp_q.size();
    seen   = '0;
    out0   = out_count;
    stall0 = stalls;
    send_chunks(n_chunks, gap_pct);
    waited = 0;
    while (exp_q.size() != 0 && waited < 40 * n_chunks) begin
      @(posedge clk);
      waited++;
    end
    repeat (TAIL_IDLE) @(posedge clk);
    if (exp_q.size() != 0) begin
      $display("Decoder stopped early with %0d symbols never emitted", exp_q.size());
      errors++;
    end
    if (out_count - out0 != n_exp) begin
      $display("Mismatch at %0d ns: %0d outputs, %0d predicted", $time, out_count - out0, n_exp);
      errors++;
    end
    if (mode == MODE_TABLE && seen != '1) begin
      $display("Some table symbols were never decoded, seen mask %h", seen);
      errors++;
    end
    if (expect_stall && stalls == stall0) begin
      $display("The window never pushed back on the input stream");
      errors++;
    end
    test_count++;
    $display("Test %-12s : %0d symbols, %0d chunks, %0d outputs, %0d stalls, %s", name,
             picks_q.size(), n_chunks, out_count - out0, stalls - stall0,
             (errors == err0) ? "ok" : "failed");
  endtask

  // ========================================
  // Main sequence and watchdog
  // ========================================
  initial begin : main
    rst            = 1'b0;
    chunk_valid    = 1'b0;
    chunk_data     = '0;
    fill_model     = 0;
    errors         = 0;
    out_count      = 0;
    accepted       = 0;
    stalls         = 0;
    planned_chunks = 0;
    test_count     = 0;
    void'($urandom(90));
    run_reset_test();
    run_stream_test("continuous", MODE_RANDOM, 300, 0, 1'b0);
    run_stream_test("gaps", MODE_REUSE, 0, 50, 1'b0);
    run_stream_test("full_table", MODE_TABLE, 0, 0, 1'b0);
    run_stream_test("tail", MODE_RANDOM, $urandom_range(15, 5), 0, 1'b0);
    run_stream_test("backpressure", MODE_RANDOM, 200, 0, 1'b1);
    $display("Summary: %0d tests, %0d outputs, %0d chunks accepted, %0d errors",
             test_count, out_count, accepted, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    bit expired;
    cycles  = 0;
    expired = 1'b0;
    while (!expired) begin
      @(posedge clk);
      cycles++;
      if (cycles > 40 * planned_chunks + 200) begin
        expired = 1'b1;
      end
    end
    $display("Run timed out after %0d cycles with %0d chunks planned", cycles, planned_chunks);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/huff_pkg.sv
window/bit_window.sv
decode/code_matcher.sv
decode/symbol_lut.sv
logic/huffman_decoder_top.sv
sim/clk_gen.sv
sim/huffman_sva.sv
sim/tb_huffman.sv

// ==== Bender.yml ====
package:
  name: huffman_decoder

sources:
  - common/huff_pkg.sv
  - window/bit_window.sv
  - decode/code_matcher.sv
  - decode/symbol_lut.sv
  - logic/huffman_decoder_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/huffman_sva.sv
      - sim/tb_huffman.sv
